//--- filelist.f
+incdir+sim
verilog/rv_pkg.sv
verilog/alu.sv
verilog/imm_gen.sv
verilog/control_fsm.sv
verilog/datapath.sv
verilog/core_top.sv
sim/tb_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_core -f filelist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

//--- sim/tb_tests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// instruction encoders with the low two opcode bits always 11
function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                 input logic [2:0] f3, input reg_idx_t rd, input opcode_t op);
    return {imm, rs1, f3, rd, op, 2'b11};
endfunction

function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                 input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, op_arith, 2'b11};
endfunction

function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2, input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store, 2'b11};
endfunction

function automatic word_t b_type(input logic [12:0] imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                 input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch, 2'b11};
endfunction

function automatic word_t u_type(input logic [19:0] imm, input reg_idx_t rd, input opcode_t op);
    return {imm, rd, op, 2'b11};
endfunction

function automatic word_t j_type(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal, 2'b11};
endfunction

task automatic load_and_reset();
    @(posedge clk);
    rstn <= 1'b0;
    foreach (mem[i]) begin
        mem[i] = '0;
    end
    foreach (prog[i]) begin
        mem[32+i] = prog[i];    // byte 128
    end
    wr_count = 0;
    tx_seen  = 1'b0;
    tx_log.delete();
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
endtask

task automatic wait_halt();
    int n;
    n = 0;
    while (halted !== 1'b1 && n < TEST_CYCLES) begin
        @(negedge clk);
        n++;
    end
    assert (halted === 1'b1) else begin
        $display("core did not halt within %0d cycles", TEST_CYCLES);
        errors++;
    end
endtask

task automatic check(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
        $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic finish_test(input string name, input int e0);
    test_count++;
    if (errors > e0) begin
        failed_tests++;
        $display("FAIL %s", name);
    end else begin
        $display("PASS %s", name);
    end
endtask

task automatic arith_test();
    int    e0;
    word_t x5;
    word_t x6;
    word_t x13;
    word_t x14;
    word_t x17;
    word_t x18;
    word_t acc;
    e0 = errors;
    prog = '{i_type(12'd53, 5'd0, 3'd0, 5'd5, op_arith_imm),
             i_type(12'hffd, 5'd0, 3'd0, 5'd6, op_arith_imm),
             r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd7), r_type(7'h20, 5'd6, 5'd5, 3'd0, 5'd8),
             r_type(7'h00, 5'd8, 5'd7, 3'd4, 5'd9), r_type(7'h00, 5'd5, 5'd9, 3'd6, 5'd11),
             r_type(7'h00, 5'd8, 5'd11, 3'd7, 5'd12), r_type(7'h00, 5'd5, 5'd6, 3'd2, 5'd13),
             r_type(7'h00, 5'd5, 5'd6, 3'd3, 5'd14), r_type(7'h00, 5'd13, 5'd5, 3'd1, 5'd15),
             r_type(7'h00, 5'd13, 5'd6, 3'd5, 5'd16), r_type(7'h20, 5'd13, 5'd6, 3'd5, 5'd17),
             i_type(12'h402, 5'd6, 3'd5, 5'd18, op_arith_imm),
             r_type(7'h00, 5'd15, 5'd12, 3'd0, 5'd10), r_type(7'h00, 5'd16, 5'd10, 3'd4, 5'd10),
             r_type(7'h00, 5'd17, 5'd10, 3'd0, 5'd10), r_type(7'h00, 5'd18, 5'd10, 3'd0, 5'd10),
             r_type(7'h00, 5'd13, 5'd10, 3'd6, 5'd10), r_type(7'h20, 5'd14, 5'd10, 3'd0, 5'd10),
             32'h0};
    load_and_reset();
    wait_halt();
    x5  = 32'd53;
    x6  = 32'hffff_fffd;
    x13 = ($signed(x6) < $signed(x5)) ? 32'd1 : 32'd0;
    x14 = (x6 < x5) ? 32'd1 : 32'd0;
    x17 = $signed(x6) >>> x13[4:0];
    x18 = $signed(x6) >>> 2;
    acc = (((x5 + x6) ^ (x5 - x6)) | x5) & (x5 - x6);
    acc = acc + (x5 << x13[4:0]);
    acc = acc ^ (x6 >> x13[4:0]);
    acc = ((acc + x17 + x18) | x13) - x14;
    check("a0_byte", word_t'(a0_byte), word_t'(acc[7:0]));
    finish_test("arith", e0);
endtask

task automatic upper_imm_test();
    int    e0;
    word_t exp;
    e0 = errors;
    prog = '{u_type(20'h12345, 5'd5, op_lui), i_type(12'd12, 5'd5, 3'd5, 5'd5, op_arith_imm),
             u_type(20'h00003, 5'd6, op_auipc), r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd10), 32'h0};
    load_and_reset();
    wait_halt();
    exp = (32'h1234_5000 >> 12) + (word_t'(RESET_PC) + 32'd8 + 32'h3000);    // auipc at word 34
    check("a0_byte", word_t'(a0_byte), word_t'(exp[7:0]));
    finish_test("upper_imm", e0);
endtask

task automatic mem_test();
    int    e0;
    word_t val;
    e0 = errors;
    prog = '{u_type(20'habcde, 5'd5, op_lui), i_type(12'h123, 5'd5, 3'd0, 5'd5, op_arith_imm),
             s_type(12'd8, 5'd5, REG_SP), i_type(12'd8, REG_SP, 3'd2, REG_A0, op_load), 32'h0};
    load_and_reset();
    wait_halt();
    val = 32'habcd_e000 + 32'h123;
    check("write count", word_t'(wr_count), 32'd1);
    check("mem_addr", word_t'(wr_addr), (SP_INIT >> 2) + 32'd2);
    check("mem_wdata", wr_data, val);
    check("a0_byte", word_t'(a0_byte), word_t'(val[7:0]));
    finish_test("memory", e0);
endtask

task automatic branch_test();
    int    e0;
    word_t exp;
    e0 = errors;
    prog = '{i_type(12'd7, 5'd0, 3'd0, 5'd5, op_arith_imm),
             i_type(12'd1, 5'd10, 3'd0, 5'd10, op_arith_imm),     // loop
             i_type(12'hfff, 5'd5, 3'd0, 5'd5, op_arith_imm),
             b_type(13'h1ff8, 5'd0, 5'd5, 3'b001), j_type(21'd12, 5'd1),
             r_type(7'h00, 5'd1, 5'd10, 3'd0, 5'd10), 32'h0,
             i_type(12'd16, 5'd10, 3'd0, 5'd10, op_arith_imm),    // called routine
             i_type(12'd0, 5'd1, 3'd0, 5'd0, op_jalr)};
    load_and_reset();
    wait_halt();
    exp = 32'd7 + 32'd16 + word_t'(RESET_PC) + 32'd20;    // count + routine + return addr
    check("a0_byte", word_t'(a0_byte), word_t'(exp[7:0]));
    finish_test("control_flow", e0);
endtask

task automatic serial_test();
    int    e0;
    byte_t sent [3];
    byte_t exp;
    e0 = errors;
    sent = '{8'h41, 8'hff, 8'h7a};
    prog.delete();
    for (int i = 0; i < 3; i++) begin
        prog.push_back(i_type(12'd0, 5'd0, 3'd0, 5'd5, op_rx));
        prog.push_back(i_type(12'd1, 5'd5, 3'd0, 5'd5, op_arith_imm));
        prog.push_back(i_type(12'd0, 5'd5, 3'd0, 5'd0, op_tx));
    end
    prog.push_back(32'h0);
    rx_q = '{sent[0], sent[1], sent[2]};
    load_and_reset();
    wait_halt();
    assert (tx_log.size() == 3) else begin
        $display("serial: %0d bytes transmitted instead of 3", tx_log.size());
        errors++;
    end
    for (int i = 0; i < 3 && i < tx_log.size(); i++) begin
        exp = sent[i] + 8'd1;    // wraps within the byte
        check("tx_data", word_t'(tx_log[i]), word_t'(exp));
    end
    finish_test("serial", e0);
endtask

task automatic halt_test();
    int e0;
    e0 = errors;
    prog = '{32'h0};
    load_and_reset();
    wait_halt();
    check("write count", word_t'(wr_count), 32'd0);
    assert (!tx_seen) else begin
        $display("tx_valid rose before halt");
        errors++;
    end
    finish_test("halt", e0);
endtask

`endif

//--- sim/tb_core.sv
`timescale 1ns/1ps

module tb_core import rv_pkg::*; ();

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 2000;

    logic   clk;
    logic   rstn;
    waddr_t pc_addr;
    word_t  instr = '0;
    waddr_t mem_addr;
    logic   mem_we;
    word_t  mem_wdata;
    word_t  mem_rdata = '0;
    byte_t  tx_data;
    logic   tx_valid;
    logic   tx_ready = 1'b0;
    logic   rx_ready;
    byte_t  rx_data = '0;
    logic   rx_valid = 1'b0;
    byte_t  a0_byte;
    logic   halted;

    word_t  mem [256];
    word_t  prog [$];
    byte_t  rx_q [$];
    byte_t  tx_log [$];
    int     wr_count;
    waddr_t wr_addr;
    word_t  wr_data;
    logic   tx_seen;
    integer seed = 32'hfd1b_48dc;
    int     rnd;
    int     errors;
    int     failed_tests;
    int     test_count;

    core_top core_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // synchronous memory, data one cycle after the address
    always @(posedge clk) begin
        instr     <= mem[pc_addr];
        mem_rdata <= mem[mem_addr];
        if (mem_we === 1'b1) begin
            mem[mem_addr] <= mem_wdata;
            wr_count = wr_count + 1;
            wr_addr  = mem_addr;
            wr_data  = mem_wdata;
        end
    end

    // serial partner
    always @(posedge clk) begin
        if (rx_valid && rx_ready) begin
            rx_q.delete(0);    // byte taken on this edge
        end
        if (rx_q.size() > 0) begin
            rx_valid <= 1'b1;
            rx_data  <= rx_q[0];
        end else begin
            rx_valid <= 1'b0;
        end
        if (tx_valid === 1'b1) begin
            tx_seen = 1'b1;
        end
        if (tx_valid && tx_ready) begin
            tx_log.push_back(tx_data);
        end
        rnd = $random(seed);
        tx_ready <= rnd[0];    // random back-pressure
    end

    `include "tb_tests.svh"

    initial begin
        rstn         = 1'b0;
        errors       = 0;
        failed_tests = 0;
        test_count   = 0;
        arith_test();
        upper_imm_test();
        mem_test();
        branch_test();
        serial_test();
        halt_test();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 test_count, failed_tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * TEST_CYCLES * 20);
        $display("watchdog expired after %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ps

module core_top import rv_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    output waddr_t pc_addr,
    input  word_t  instr,
    output waddr_t mem_addr,
    output logic   mem_we,
    output word_t  mem_wdata,
    input  word_t  mem_rdata,
    output byte_t  tx_data,
    output logic   tx_valid,
    input  logic   tx_ready,
    output logic   rx_ready,
    input  byte_t  rx_data,
    input  logic   rx_valid,
    output byte_t  a0_byte,
    output logic   halted
);

    ctrl_t ctrl;
    logic  alu_zero;
    logic  rx_fire;

    assign rx_fire = rx_valid & rx_ready;    // byte taken this cycle
    assign mem_we  = ctrl.mem_write;

    control_fsm control_fsm_inst (
        .clk      (clk),
        .rstn     (rstn),
        .instr    (instr),
        .alu_zero (alu_zero),
        .ctrl     (ctrl),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .rx_ready (rx_ready),
        .rx_valid (rx_valid),
        .halted   (halted)
    );

    datapath datapath_inst (
        .clk       (clk),
        .rstn      (rstn),
        .instr     (instr),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .rx_data   (rx_data),
        .rx_fire   (rx_fire),
        .pc_addr   (pc_addr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .tx_data   (tx_data),
        .a0_byte   (a0_byte),
        .alu_zero  (alu_zero)
    );

endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ps

module datapath import rv_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  word_t  instr,
    input  ctrl_t  ctrl,
    input  word_t  mem_rdata,
    input  byte_t  rx_data,
    input  logic   rx_fire,
    output waddr_t pc_addr,
    output waddr_t mem_addr,
    output word_t  mem_wdata,
    output byte_t  tx_data,
    output byte_t  a0_byte,
    output logic   alu_zero
);

    pc_t      pc;
    word_t    regs [32];
    word_t    a;
    word_t    b;
    word_t    result;
    byte_t    rx_byte;
    word_t    imm;
    word_t    src_a;
    word_t    src_b;
    word_t    alu_result;
    word_t    wb_data;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    imm_gen imm_gen_inst (
        .instr (instr),
        .sel   (ctrl.src_b),
        .imm   (imm)
    );

    always_comb begin
        case (ctrl.src_a)
            src_a_pc:  src_a = {{(XLEN-PC_W){1'b0}}, pc};
            src_a_reg: src_a = a;
            default:   src_a = '0;
        endcase
    end

    always_comb begin
        case (ctrl.src_b)
            src_b_reg:  src_b = b;
            src_b_four: src_b = 32'd4;
            default:    src_b = imm;
        endcase
    end

    alu alu_inst (
        .a           (src_a),
        .b           (src_b),
        .op          (ctrl.alu_op),
        .sub_sra     (ctrl.sub_sra),
        .arith_shift (ctrl.arith_shift),
        .result      (alu_result),
        .zero        (alu_zero)
    );

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wb_data = mem_rdata;
            wb_rx:   wb_data = {{(XLEN-8){1'b0}}, rx_byte};
            default: wb_data = result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= RESET_PC;
        end else if (ctrl.pc_write) begin
            pc <= alu_result[PC_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= (i == REG_SP) ? SP_INIT : '0;
            end
        end else if (ctrl.reg_write && rd != '0) begin    // x0 stays zero
            regs[rd] <= wb_data;
        end
    end

    // operand latches and result follow every cycle
    always_ff @(posedge clk) begin
        a      <= regs[rs1];
        b      <= regs[rs2];
        result <= alu_result;
        if (rx_fire) begin
            rx_byte <= rx_data;
        end
    end

    assign pc_addr   = pc[PC_W-1:2];
    assign mem_addr  = result[PC_W-1:2];    // word address
    assign mem_wdata = b;
    assign tx_data   = a[7:0];
    assign a0_byte   = regs[REG_A0][7:0];

endmodule

//--- verilog/control_fsm.sv
`timescale 1ns/1ps

module control_fsm import rv_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  word_t instr,
    input  logic  alu_zero,
    output ctrl_t ctrl,
    output logic  tx_valid,
    input  logic  tx_ready,
    output logic  rx_ready,
    input  logic  rx_valid,
    output logic  halted
);

    state_t     state;
    opcode_t    opcode;
    reg_idx_t   rd;
    logic [2:0] funct3;
    src_b_t     imm_sel;
    logic       taken;

    assign opcode = instr[6:2];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    // immediate format of the current instruction
    always_comb begin
        case (opcode)
            op_load, op_arith_imm, op_jalr: imm_sel = src_b_imm_i;
            op_store:                       imm_sel = src_b_imm_s;
            op_lui, op_auipc:               imm_sel = src_b_imm_u;
            op_branch:                      imm_sel = src_b_imm_sb;
            op_jal:                         imm_sel = src_b_imm_uj;
            default:                        imm_sel = src_b_reg;
        endcase
    end

    // beq/bne compare by subtract, the others by set-less-than
    assign taken  = alu_zero ^ funct3[0] ^ (ctrl.alu_op != alu_add_sub);
    assign halted = (state == halt);

    // plain add, no writes except the optional pc update
    function automatic ctrl_t add_ctrl(input src_a_t sa, input src_b_t sb, input logic pcw);
        ctrl_t c;
        c          = '0;
        c.pc_write = pcw;
        c.src_a    = sa;
        c.src_b    = sb;
        c.alu_op   = alu_add_sub;
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= init;
            ctrl     <= '0;
            tx_valid <= 1'b0;
            rx_ready <= 1'b0;
        end else begin
            case (state)
                init, nextpc, branch, jump: begin
                    state          <= fetch;
                    ctrl.pc_write  <= 1'b0;
                    ctrl.reg_write <= 1'b0;    // link write in jump
                end
                fetch: state <= decode;    // instr valid next cycle
                decode: begin
                    if (instr == '0) begin
                        state <= halt;
                    end else begin
                        case (opcode)
                            op_load, op_store: begin
                                state <= memaddr;
                                ctrl  <= add_ctrl(src_a_reg, imm_sel, 1'b0);
                            end
                            op_rx: begin
                                state    <= recv_wait;
                                rx_ready <= 1'b1;
                            end
                            op_tx: begin
                                state    <= transmit;
                                tx_valid <= 1'b1;
                            end
                            op_arith_imm: begin
                                state            <= arith_exec;
                                ctrl.src_a       <= src_a_reg;
                                ctrl.src_b       <= src_b_imm_i;
                                ctrl.alu_op      <= funct3;
                                ctrl.sub_sra     <= 1'b0;    // no subi
                                ctrl.arith_shift <= instr[30];
                            end
                            op_arith: begin
                                state            <= arith_exec;
                                ctrl.src_a       <= src_a_reg;
                                ctrl.src_b       <= src_b_reg;
                                ctrl.alu_op      <= funct3;
                                ctrl.sub_sra     <= instr[30];
                                ctrl.arith_shift <= instr[30];
                            end
                            op_lui: begin
                                state <= arith_exec;
                                ctrl  <= add_ctrl(src_a_zero, src_b_imm_u, 1'b0);
                            end
                            op_auipc: begin
                                state <= arith_exec;
                                ctrl  <= add_ctrl(src_a_pc, src_b_imm_u, 1'b0);
                            end
                            op_branch: begin
                                state        <= compare;
                                ctrl.src_a   <= src_a_reg;
                                ctrl.src_b   <= src_b_reg;
                                ctrl.alu_op  <= {1'b0, funct3[2:1]};
                                ctrl.sub_sra <= 1'b1;
                            end
                            op_jal, op_jalr: begin
                                state <= link;
                                ctrl  <= add_ctrl(src_a_pc, src_b_four, 1'b0);   // pc+4
                            end
                            default: state <= halt;
                        endcase
                    end
                end
                memaddr: begin
                    if (opcode == op_load) begin
                        state <= memread;
                    end else begin
                        state          <= memwrite;
                        ctrl.mem_write <= 1'b1;
                    end
                end
                memread: begin
                    state          <= writeback;
                    ctrl.reg_write <= 1'b1;
                    ctrl.wb_sel    <= wb_mem;
                end
                arith_exec: begin
                    state          <= alu_wb;
                    ctrl.reg_write <= 1'b1;
                    ctrl.wb_sel    <= wb_alu;
                end
                writeback, memwrite, alu_wb, recv_wb: begin
                    state <= nextpc;
                    ctrl  <= add_ctrl(src_a_pc, src_b_four, 1'b1);
                end
                transmit: begin
                    // hold valid and data until the partner takes the byte
                    if (tx_ready) begin
                        state    <= nextpc;
                        tx_valid <= 1'b0;
                        ctrl     <= add_ctrl(src_a_pc, src_b_four, 1'b1);
                    end
                end
                compare: begin
                    state <= branch;
                    ctrl  <= add_ctrl(src_a_pc, taken ? src_b_imm_sb : src_b_four, 1'b1);
                end
                link: begin
                    state          <= jump;
                    ctrl           <= add_ctrl(opcode == op_jal ? src_a_pc : src_a_reg,
                                               imm_sel, 1'b1);
                    ctrl.reg_write <= (rd != '0);
                end
                recv_wait: begin
                    if (rx_valid) begin
                        state          <= recv_wb;
                        rx_ready       <= 1'b0;
                        ctrl.reg_write <= 1'b1;
                        ctrl.wb_sel    <= wb_rx;
                    end
                end
                default: state <= halt;    // halt is final
            endcase
        end
    end

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rv_pkg::*; (
    input  word_t  instr,
    input  src_b_t sel,
    output word_t  imm
);

    always_comb begin
        case (sel)
            src_b_imm_i:  imm = {{20{instr[31]}}, instr[31:20]};
            src_b_imm_s:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            src_b_imm_u:  imm = {instr[31:12], 12'b0};
            src_b_imm_sb: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            src_b_imm_uj: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default:      imm = '0;    // reg, four
        endcase
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    input  logic    sub_sra,
    input  logic    arith_shift,
    output word_t   result,
    output logic    zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add_sub: result = sub_sra ? a - b : a + b;
            alu_shift_l: result = a << shamt;
            alu_lt:      result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_lt_u:    result = {{(XLEN-1){1'b0}}, a < b};
            alu_xor:     result = a ^ b;
            alu_shift_r: begin
                // kept apart so the signed shift stays signed
                if (arith_shift) begin
                    result = $signed(a) >>> shamt;
                end else begin
                    result = a >> shamt;
                end
            end
            alu_or:      result = a | b;
            default:     result = a & b;
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- verilog/rv_pkg.sv
package rv_pkg;

    localparam int XLEN    = 32;
    localparam int PC_W    = 10;
    localparam int WADDR_W = PC_W - 2;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [WADDR_W-1:0] waddr_t;
    typedef logic [PC_W-1:0]    pc_t;
    typedef logic [4:0]         reg_idx_t;
    typedef logic [7:0]         byte_t;
    typedef logic [4:0]         opcode_t;   // instr[6:2]
    typedef logic [2:0]         alu_op_t;

    localparam pc_t      RESET_PC = 10'd128;
    localparam word_t    SP_INIT  = 32'd512;
    localparam reg_idx_t REG_A0   = 5'd10;
    localparam reg_idx_t REG_SP   = 5'd2;

    // major opcodes
    localparam opcode_t op_load      = 5'h00;
    localparam opcode_t op_rx        = 5'h02;
    localparam opcode_t op_arith_imm = 5'h04;
    localparam opcode_t op_auipc     = 5'h05;
    localparam opcode_t op_tx        = 5'h06;
    localparam opcode_t op_store     = 5'h08;
    localparam opcode_t op_arith     = 5'h0C;
    localparam opcode_t op_lui       = 5'h0D;
    localparam opcode_t op_branch    = 5'h18;
    localparam opcode_t op_jalr      = 5'h19;
    localparam opcode_t op_jal       = 5'h1B;

    // alu ops, same encoding as funct3
    localparam alu_op_t alu_add_sub = 3'b000;
    localparam alu_op_t alu_shift_l = 3'b001;
    localparam alu_op_t alu_lt      = 3'b010;
    localparam alu_op_t alu_lt_u    = 3'b011;
    localparam alu_op_t alu_xor     = 3'b100;
    localparam alu_op_t alu_shift_r = 3'b101;
    localparam alu_op_t alu_or      = 3'b110;
    localparam alu_op_t alu_and     = 3'b111;

    typedef enum logic [1:0] {src_a_pc, src_a_reg, src_a_zero} src_a_t;

    typedef enum logic [2:0] {
        src_b_reg, src_b_four, src_b_imm_i, src_b_imm_s,
        src_b_imm_u, src_b_imm_sb, src_b_imm_uj
    } src_b_t;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_rx} wb_sel_t;

    typedef enum logic [4:0] {
        init, nextpc, fetch, decode, memaddr, memread, writeback, memwrite,
        transmit, arith_exec, alu_wb, compare, branch, link, jump,
        recv_wait, recv_wb, halt
    } state_t;

    typedef struct packed {
        logic    pc_write;
        logic    mem_write;
        logic    reg_write;
        wb_sel_t wb_sel;
        src_a_t  src_a;
        src_b_t  src_b;
        alu_op_t alu_op;
        logic    sub_sra;       // subtract on add_sub
        logic    arith_shift;   // sra on shift_r
    } ctrl_t;

endpackage
